//--- gain_regs_pkg.sv
`default_nettype none

package gain_regs_pkg;

  //////////////////////////////////////////////////
  // Wishbone bus widths
  //////////////////////////////////////////////////

  // Word address
  localparam int WB_ADDR_W = 4;
  localparam int WB_DATA_W = 32;

  //////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////

  localparam logic [WB_ADDR_W-1:0] REG_GAIN  = 4'd0;
  localparam logic [WB_ADDR_W-1:0] REG_CTRL  = 4'd1;
  localparam logic [WB_ADDR_W-1:0] REG_COUNT = 4'd2;

  // Field layout
  localparam int GAIN_FIELD_W   = 16;
  localparam int CTRL_CLEAR_BIT = 0;
  localparam int COUNT_W        = 32;

  // Unity gain with 11 fraction bits
  localparam logic [GAIN_FIELD_W-1:0] GAIN_RESET = 16'd2048;

  localparam logic [WB_DATA_W-1:0] RB_UNMAPPED = 32'h0BADC0DE;

endpackage

`default_nettype wire

//--- gain_sample_pkg.sv
`default_nettype none

package gain_sample_pkg;

  //////////////////////////////////////////////////
  // Sample and product widths
  //////////////////////////////////////////////////

  // One I or Q part, two of them per stream word
  localparam int SAMPLE_W = 16;
  localparam int GAIN_W   = 16;

  // Full signed product of part and gain
  localparam int PROD_W = SAMPLE_W + GAIN_W;

  // Arithmetic right shift applied to each product
  localparam int FRAC_BITS = 11;

  //////////////////////////////////////////////////
  // Saturation limits
  //////////////////////////////////////////////////

  // 32767
  localparam logic signed [SAMPLE_W-1:0] SAT_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};
  // -32768
  localparam logic signed [SAMPLE_W-1:0] SAT_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};

endpackage

`default_nettype wire

//--- gain_ctrl.sv
`default_nettype none

module gain_ctrl (
  input  wire logic                                        ce_clk,
  input  wire logic                                        i_arst_n,
  // Wishbone classic slave
  input  wire logic                                        i_wb_cyc,
  input  wire logic                                        i_wb_stb,
  input  wire logic                                        i_wb_we,
  input  wire logic        [gain_regs_pkg::WB_ADDR_W-1:0]  i_wb_adr,
  input  wire logic        [gain_regs_pkg::WB_DATA_W-1:0]  i_wb_dat,
  output logic             [gain_regs_pkg::WB_DATA_W-1:0]  o_wb_dat,
  output logic                                             o_wb_ack,
  // Output stream handshake
  input  wire logic                                        i_out_valid,
  input  wire logic                                        i_out_ready,
  // To the datapath
  output logic signed      [gain_sample_pkg::GAIN_W-1:0]   o_gain,
  output logic                                             o_clear
);

  logic                                wb_hit;
  logic                                wb_wr;
  logic                                clear_req;
  logic [gain_regs_pkg::COUNT_W-1:0]   count;

  //////////////////////////////////////////////////
  // Bus decode
  //////////////////////////////////////////////////

  // New access only when ack is not already up
  assign wb_hit = i_wb_cyc && i_wb_stb && !o_wb_ack;
  assign wb_wr  = wb_hit && i_wb_we;

  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_wb_ack <= 1'b0;
    end else begin
      o_wb_ack <= wb_hit;
    end
  end

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_gain <= gain_regs_pkg::GAIN_RESET;
    end else if (wb_wr && (i_wb_adr == gain_regs_pkg::REG_GAIN)) begin
      o_gain <= i_wb_dat[gain_regs_pkg::GAIN_FIELD_W-1:0];
    end
  end

  // CLEAR write becomes a pulse one cycle after its ack
  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      clear_req <= 1'b0;
      o_clear   <= 1'b0;
    end else begin
      clear_req <= wb_wr && (i_wb_adr == gain_regs_pkg::REG_CTRL) &&
                   i_wb_dat[gain_regs_pkg::CTRL_CLEAR_BIT];
      o_clear   <= clear_req;
    end
  end

  // Output transfer counter
  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      count <= '0;
    end else if (o_clear) begin
      count <= '0;
    end else if (i_out_valid && i_out_ready) begin
      count <= count + 1'b1;
    end
  end

  // Read data held for the ack cycle
  always_ff @(posedge ce_clk) begin
    if (wb_hit) begin
      case (i_wb_adr)
        gain_regs_pkg::REG_GAIN:
          o_wb_dat <= {{(gain_regs_pkg::WB_DATA_W-gain_regs_pkg::GAIN_FIELD_W){1'b0}}, o_gain};
        gain_regs_pkg::REG_CTRL:  o_wb_dat <= '0;
        gain_regs_pkg::REG_COUNT: o_wb_dat <= count;
        default:                  o_wb_dat <= gain_regs_pkg::RB_UNMAPPED;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Bus protocol checks
  //////////////////////////////////////////////////

  a_ack_after_req: assert property (@(posedge ce_clk) disable iff (!i_arst_n)
    o_wb_ack |-> $past(i_wb_cyc && i_wb_stb));

  a_ack_single: assert property (@(posedge ce_clk) disable iff (!i_arst_n)
    o_wb_ack |=> !o_wb_ack);

endmodule

`default_nettype wire

//--- gain_mult.sv
`default_nettype none

module gain_mult (
  input  wire logic                                          ce_clk,
  input  wire logic                                          i_arst_n,
  input  wire logic signed [gain_sample_pkg::GAIN_W-1:0]     i_gain,
  input  wire logic                                          i_clear,
  // Input stream, I in the upper half
  input  wire logic        [2*gain_sample_pkg::SAMPLE_W-1:0] i_tdata,
  input  wire logic                                          i_tlast,
  input  wire logic                                          i_tvalid,
  output logic                                               o_s_ready,
  // Shifted products, two 32-bit lanes
  output logic             [2*gain_sample_pkg::PROD_W-1:0]   o_tdata,
  output logic                                               o_tlast,
  output logic                                               o_tvalid,
  input  wire logic                                          i_tready
);

  logic                                         advance;

  // Operand stage
  logic signed [gain_sample_pkg::SAMPLE_W-1:0]  op_i;
  logic signed [gain_sample_pkg::SAMPLE_W-1:0]  op_q;
  logic signed [gain_sample_pkg::GAIN_W-1:0]    op_gain;
  logic                                         op_last;
  logic                                         op_valid;

  // Product stage
  logic signed [gain_sample_pkg::PROD_W-1:0]    prod_i;
  logic signed [gain_sample_pkg::PROD_W-1:0]    prod_q;
  logic                                         prod_last;
  logic                                         prod_valid;

  // Shift stage
  logic signed [gain_sample_pkg::PROD_W-1:0]    shr_i;
  logic signed [gain_sample_pkg::PROD_W-1:0]    shr_q;
  logic                                         shr_last;
  logic                                         shr_valid;

  // Whole pipe moves as one while the last stage can drain
  assign advance   = !shr_valid || i_tready;
  assign o_s_ready = advance;

  //////////////////////////////////////////////////
  // Valid chain
  //////////////////////////////////////////////////

  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      op_valid   <= 1'b0;
      prod_valid <= 1'b0;
      shr_valid  <= 1'b0;
    end else if (i_clear) begin
      op_valid   <= 1'b0;
      prod_valid <= 1'b0;
      shr_valid  <= 1'b0;
    end else if (advance) begin
      op_valid   <= i_tvalid;
      prod_valid <= op_valid;
      shr_valid  <= prod_valid;
    end
  end

  //////////////////////////////////////////////////
  // Data path
  //////////////////////////////////////////////////

  always_ff @(posedge ce_clk) begin
    if (advance) begin
      // Gain captured with the sample it applies to
      op_i      <= i_tdata[2*gain_sample_pkg::SAMPLE_W-1:gain_sample_pkg::SAMPLE_W];
      op_q      <= i_tdata[gain_sample_pkg::SAMPLE_W-1:0];
      op_gain   <= i_gain;
      op_last   <= i_tlast;

      prod_i    <= op_i * op_gain;
      prod_q    <= op_q * op_gain;
      prod_last <= op_last;

      // Truncates toward minus infinity
      shr_i     <= prod_i >>> gain_sample_pkg::FRAC_BITS;
      shr_q     <= prod_q >>> gain_sample_pkg::FRAC_BITS;
      shr_last  <= prod_last;
    end
  end

  assign o_tdata  = {shr_i, shr_q};
  assign o_tlast  = shr_last;
  assign o_tvalid = shr_valid;

  // Held output survives a stall
  a_hold_stall: assert property (@(posedge ce_clk) disable iff (!i_arst_n)
    (o_tvalid && !i_tready && !i_clear) |=>
      (o_tvalid && $stable(o_tdata) && $stable(o_tlast)));

endmodule

`default_nettype wire

//--- gain_clip.sv
`default_nettype none

module gain_clip (
  input  wire logic                                          ce_clk,
  input  wire logic                                          i_arst_n,
  input  wire logic                                          i_clear,
  // Two 32-bit lanes, I in the upper half
  input  wire logic        [2*gain_sample_pkg::PROD_W-1:0]   i_tdata,
  input  wire logic                                          i_tlast,
  input  wire logic                                          i_tvalid,
  output logic                                               o_tready,
  // Packed 16-bit I and Q
  output logic             [2*gain_sample_pkg::SAMPLE_W-1:0] o_tdata,
  output logic                                               o_tlast,
  output logic                                               o_tvalid,
  input  wire logic                                          i_tready
);

  logic                                        advance;
  logic        [2*gain_sample_pkg::SAMPLE_W-1:0] clip_word;

  // Clamp one lane into the 16-bit signed range
  function automatic logic [gain_sample_pkg::SAMPLE_W-1:0] sat_lane(
    input logic signed [gain_sample_pkg::PROD_W-1:0] lane
  );
    logic [gain_sample_pkg::SAMPLE_W-1:0] result;
    if (lane > gain_sample_pkg::SAT_MAX) begin
      result = gain_sample_pkg::SAT_MAX;
    end else if (lane < gain_sample_pkg::SAT_MIN) begin
      result = gain_sample_pkg::SAT_MIN;
    end else begin
      result = lane[gain_sample_pkg::SAMPLE_W-1:0];
    end
    return result;
  endfunction

  assign clip_word = {
    sat_lane(i_tdata[2*gain_sample_pkg::PROD_W-1:gain_sample_pkg::PROD_W]),
    sat_lane(i_tdata[gain_sample_pkg::PROD_W-1:0])
  };

  // Same stall rule as the multiplier
  assign advance  = !o_tvalid || i_tready;
  assign o_tready = advance;

  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_tvalid <= 1'b0;
    end else if (i_clear) begin
      o_tvalid <= 1'b0;
    end else if (advance) begin
      o_tvalid <= i_tvalid;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (advance) begin
      o_tdata <= clip_word;
      o_tlast <= i_tlast;
    end
  end

  a_out_stable: assert property (@(posedge ce_clk) disable iff (!i_arst_n)
    (o_tvalid && !i_tready && !i_clear) |=>
      (o_tvalid && $stable(o_tdata) && $stable(o_tlast)));

endmodule

`default_nettype wire

//--- digital_gain_top.sv
`default_nettype none

module digital_gain_top (
  input  wire logic                                          ce_clk,
  input  wire logic                                          i_arst_n,
  // Wishbone classic slave
  input  wire logic                                          i_wb_cyc,
  input  wire logic                                          i_wb_stb,
  input  wire logic                                          i_wb_we,
  input  wire logic        [gain_regs_pkg::WB_ADDR_W-1:0]    i_wb_adr,
  input  wire logic        [gain_regs_pkg::WB_DATA_W-1:0]    i_wb_dat,
  output logic             [gain_regs_pkg::WB_DATA_W-1:0]    o_wb_dat,
  output logic                                               o_wb_ack,
  // Stream input
  input  wire logic        [2*gain_sample_pkg::SAMPLE_W-1:0] i_s_tdata,
  input  wire logic                                          i_s_tlast,
  input  wire logic                                          i_s_tvalid,
  output logic                                               o_s_tready,
  // Stream output
  output logic             [2*gain_sample_pkg::SAMPLE_W-1:0] o_m_tdata,
  output logic                                               o_m_tlast,
  output logic                                               o_m_tvalid,
  input  wire logic                                          i_m_tready
);

  logic signed [gain_sample_pkg::GAIN_W-1:0]     gain_value;
  logic                                          clear_pulse;

  // Multiplier to clip stage
  logic        [2*gain_sample_pkg::PROD_W-1:0]   mult_tdata;
  logic                                          mult_tlast;
  logic                                          mult_tvalid;
  logic                                          mult_tready;

  //////////////////////////////////////////////////
  // Register bank
  //////////////////////////////////////////////////

  gain_ctrl u_ctrl (
    .ce_clk      (ce_clk),
    .i_arst_n    (i_arst_n),
    .i_wb_cyc    (i_wb_cyc),
    .i_wb_stb    (i_wb_stb),
    .i_wb_we     (i_wb_we),
    .i_wb_adr    (i_wb_adr),
    .i_wb_dat    (i_wb_dat),
    .o_wb_dat    (o_wb_dat),
    .o_wb_ack    (o_wb_ack),
    .i_out_valid (o_m_tvalid),
    .i_out_ready (i_m_tready),
    .o_gain      (gain_value),
    .o_clear     (clear_pulse)
  );

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  gain_mult u_mult (
    .ce_clk    (ce_clk),
    .i_arst_n  (i_arst_n),
    .i_gain    (gain_value),
    .i_clear   (clear_pulse),
    .i_tdata   (i_s_tdata),
    .i_tlast   (i_s_tlast),
    .i_tvalid  (i_s_tvalid),
    .o_s_ready (o_s_tready),
    .o_tdata   (mult_tdata),
    .o_tlast   (mult_tlast),
    .o_tvalid  (mult_tvalid),
    .i_tready  (mult_tready)
  );

  gain_clip u_clip (
    .ce_clk   (ce_clk),
    .i_arst_n (i_arst_n),
    .i_clear  (clear_pulse),
    .i_tdata  (mult_tdata),
    .i_tlast  (mult_tlast),
    .i_tvalid (mult_tvalid),
    .o_tready (mult_tready),
    .o_tdata  (o_m_tdata),
    .o_tlast  (o_m_tlast),
    .o_tvalid (o_m_tvalid),
    .i_tready (i_m_tready)
  );

endmodule

`default_nettype wire

//--- tb_digital_gain.sv
`default_nettype none

module tb_digital_gain;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD      = 100;
  localparam int N_UNITY         = 200;
  localparam int N_GAINS         = 10;
  localparam int N_PER_GAIN      = 100;
  localparam int N_BP            = 300;
  localparam int N_CLEAR_PRE     = 4;
  localparam int N_CLEAR_POST    = 50;
  localparam int N_TOTAL         = N_UNITY + N_GAINS * N_PER_GAIN + N_BP +
                                   N_CLEAR_PRE + N_CLEAR_POST;
  localparam int WATCHDOG_CYCLES = N_TOTAL * 8 + 2000;

  logic        ce_clk;
  logic        i_arst_n;
  logic        i_wb_cyc;
  logic        i_wb_stb;
  logic        i_wb_we;
  logic [3:0]  i_wb_adr;
  logic [31:0] i_wb_dat;
  logic [31:0] o_wb_dat;
  logic        o_wb_ack;
  logic [31:0] i_s_tdata;
  logic        i_s_tlast;
  logic        i_s_tvalid;
  logic        o_s_tready;
  logic [31:0] o_m_tdata;
  logic        o_m_tlast;
  logic        o_m_tvalid;
  logic        i_m_tready;

  integer             seed;
  logic signed [15:0] model_gain;
  logic               bp_mode;
  // Expected output words with tlast in bit 32
  logic [32:0]        exp_q[$];
  int                 in_count;
  int                 out_count;
  int                 error_count;
  int                 check_count;
  int                 test_count;
  int                 test_start_errors;
  string              current_test;

  digital_gain_top UUT (
    .ce_clk     (ce_clk),
    .i_arst_n   (i_arst_n),
    .i_wb_cyc   (i_wb_cyc),
    .i_wb_stb   (i_wb_stb),
    .i_wb_we    (i_wb_we),
    .i_wb_adr   (i_wb_adr),
    .i_wb_dat   (i_wb_dat),
    .o_wb_dat   (o_wb_dat),
    .o_wb_ack   (o_wb_ack),
    .i_s_tdata  (i_s_tdata),
    .i_s_tlast  (i_s_tlast),
    .i_s_tvalid (i_s_tvalid),
    .o_s_tready (o_s_tready),
    .o_m_tdata  (o_m_tdata),
    .o_m_tlast  (o_m_tlast),
    .o_m_tvalid (o_m_tvalid),
    .i_m_tready (i_m_tready)
  );

  initial begin
    ce_clk = 1'b0;
    forever #(CLK_PERIOD / 2) ce_clk = ~ce_clk;
  end

  //////////////////////////////////////////////////
  // Reference model and checks
  //////////////////////////////////////////////////

  // Part times gain shifted down by 11 and clamped to 16 bits
  function automatic logic [15:0] scale_part(input logic signed [15:0] part,
                                             input logic signed [15:0] gain);
    longint full;
    longint shifted;
    logic [15:0] result;
    full    = longint'(part) * longint'(gain);
    shifted = full >>> gain_sample_pkg::FRAC_BITS;
    if (shifted > longint'(gain_sample_pkg::SAT_MAX)) begin
      result = gain_sample_pkg::SAT_MAX;
    end else if (shifted < longint'(gain_sample_pkg::SAT_MIN)) begin
      result = gain_sample_pkg::SAT_MIN;
    end else begin
      result = shifted[15:0];
    end
    return result;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
      error_count++;
    end
  endtask

  // Model fed on input handshakes and checked on output handshakes
  always @(posedge ce_clk) begin
    logic [32:0] entry;
    if (i_arst_n && i_s_tvalid && o_s_tready) begin
      entry = {i_s_tlast, scale_part(i_s_tdata[31:16], model_gain),
               scale_part(i_s_tdata[15:0], model_gain)};
      exp_q.push_back(entry);
      in_count++;
    end
    if (i_arst_n && o_m_tvalid && i_m_tready) begin
      if (exp_q.size() == 0) begin
        $display("Test %s: output word %h arrived with no sample pending",
                 current_test, o_m_tdata);
        error_count++;
      end else begin
        entry = exp_q.pop_front();
        check_value(current_test, entry[31:0], o_m_tdata);
        check_value(current_test, {31'd0, entry[32]}, {31'd0, o_m_tlast});
      end
      out_count++;
    end
  end

  //////////////////////////////////////////////////
  // Bus and stream tasks
  //////////////////////////////////////////////////

  task automatic wb_write(input logic [3:0] addr, input logic [31:0] data);
    i_wb_cyc = 1'b1;
    i_wb_stb = 1'b1;
    i_wb_we  = 1'b1;
    i_wb_adr = addr;
    i_wb_dat = data;
    @(negedge ce_clk);
    while (!o_wb_ack) @(negedge ce_clk);
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
    i_wb_we  = 1'b0;
  endtask

  task automatic wb_read(input logic [3:0] addr, output logic [31:0] data);
    i_wb_cyc = 1'b1;
    i_wb_stb = 1'b1;
    i_wb_we  = 1'b0;
    i_wb_adr = addr;
    @(negedge ce_clk);
    while (!o_wb_ack) @(negedge ce_clk);
    data     = o_wb_dat;
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
  endtask

  // Waits whole clocks and toggles ready at random under back-pressure
  task automatic idle_cycles(input int n);
    logic [31:0] rnd;
    repeat (n) begin
      @(negedge ce_clk);
      if (bp_mode) begin
        rnd        = $random(seed);
        i_m_tready = rnd[0];
      end
    end
  endtask

  task automatic send_sample(input logic [31:0] data, input logic last);
    int start;
    start      = in_count;
    i_s_tdata  = data;
    i_s_tlast  = last;
    i_s_tvalid = 1'b1;
    while (in_count == start) idle_cycles(1);
    i_s_tvalid = 1'b0;
  endtask

  task automatic send_random(input int n);
    logic [31:0] data;
    logic [31:0] rnd;
    repeat (n) begin
      data = $random(seed);
      rnd  = $random(seed);
      send_sample(data, rnd[0]);
      if (bp_mode && rnd[2:1] == 2'b00) idle_cycles(int'(rnd[5:3]) + 1);
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) idle_cycles(1);
  endtask

  task automatic begin_test(input string name);
    current_test      = name;
    test_start_errors = error_count;
  endtask

  task automatic end_test();
    test_count++;
    $display("Test %s done with %0d errors", current_test, error_count - test_start_errors);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] rd;
    logic [31:0] rnd;
    logic [15:0] new_gain;
    seed        = 92;
    i_arst_n    = 1'b0;
    i_wb_cyc    = 1'b0;
    i_wb_stb    = 1'b0;
    i_wb_we     = 1'b0;
    i_wb_adr    = '0;
    i_wb_dat    = '0;
    i_s_tdata   = '0;
    i_s_tlast   = 1'b0;
    i_s_tvalid  = 1'b0;
    i_m_tready  = 1'b1;
    bp_mode     = 1'b0;
    model_gain  = 16'sd2048;
    in_count    = 0;
    out_count   = 0;
    error_count = 0;
    check_count = 0;
    test_count  = 0;
    repeat (5) @(posedge ce_clk);
    @(negedge ce_clk);
    i_arst_n = 1'b1;
    @(negedge ce_clk);

    begin_test("reset_state");
    check_value(current_test, 32'd0, {31'd0, o_m_tvalid});
    check_value(current_test, 32'd1, {31'd0, o_s_tready});
    wb_read(gain_regs_pkg::REG_GAIN, rd);
    check_value(current_test, 32'd2048, rd);
    wb_read(gain_regs_pkg::REG_COUNT, rd);
    check_value(current_test, 32'd0, rd);
    wb_read(gain_regs_pkg::REG_CTRL, rd);
    check_value(current_test, 32'd0, rd);
    end_test();

    begin_test("unity_gain");
    send_random(N_UNITY);
    wait_drain();
    end_test();

    // First two gains force saturation at both limits
    begin_test("random_gains");
    for (int g = 0; g < N_GAINS; g++) begin
      rnd      = $random(seed);
      new_gain = (g == 0) ? 16'h7FFF : (g == 1) ? 16'h8000 : rnd[15:0];
      wb_write(gain_regs_pkg::REG_GAIN, {16'h0000, new_gain});
      model_gain = new_gain;
      send_random(N_PER_GAIN);
      wait_drain();
    end
    end_test();

    begin_test("back_pressure");
    bp_mode = 1'b1;
    send_random(N_BP);
    bp_mode    = 1'b0;
    i_m_tready = 1'b1;
    wait_drain();
    wb_read(gain_regs_pkg::REG_COUNT, rd);
    check_value(current_test, out_count, rd);
    end_test();

    // Fill the stalled pipe and then flush it
    begin_test("clear");
    i_m_tready = 1'b0;
    send_random(N_CLEAR_PRE);
    wb_write(gain_regs_pkg::REG_CTRL, 32'h0000_0001);
    idle_cycles(2);
    exp_q.delete();
    out_count  = 0;
    i_m_tready = 1'b1;
    idle_cycles(8);
    check_value(current_test, 32'd0, {31'd0, o_m_tvalid});
    wb_read(gain_regs_pkg::REG_COUNT, rd);
    check_value(current_test, 32'd0, rd);
    send_random(N_CLEAR_POST);
    wait_drain();
    // Counter restarts from the flush
    wb_read(gain_regs_pkg::REG_COUNT, rd);
    check_value(current_test, out_count, rd);
    end_test();

    begin_test("unmapped");
    for (int a = 3; a < 16; a++) begin
      wb_read(a[3:0], rd);
      check_value(current_test, 32'h0BADC0DE, rd);
      rnd = $random(seed);
      wb_write(a[3:0], rnd);
    end
    wb_read(gain_regs_pkg::REG_GAIN, rd);
    check_value(current_test, {16'h0000, model_gain}, rd);
    end_test();

    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Run length bound scales with the total number of samples
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge ce_clk);
    $display("Timeout: the run did not end within %0d clock cycles", WATCHDOG_CYCLES);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
gain_regs_pkg.sv
gain_sample_pkg.sv
gain_ctrl.sv
gain_mult.sv
gain_clip.sv
digital_gain_top.sv
tb_digital_gain.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the digital gain testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_digital_gain --Mdir "$BUILD_DIR" -f compile.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

( "./$BUILD_DIR/Vtb_digital_gain"; echo "$?" > "$BUILD_DIR/run_status" ) 2>&1 | tee "$LOG"
run_status=$(cat "$BUILD_DIR/run_status")
if [ "$run_status" -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
  exit 1
fi
if ! grep -q "Finished with no errors" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0
